// File: files.f
hw/periph_pkg.sv
hw/periph_region_decode.sv
hw/boot_ram.sv
hw/gpio_regs.sv
hw/periph_top.sv
verif/periph_assertions.sv
verif/periph_tb.sv

// File: hw/boot_ram.sv
`timescale 1ns/10ps
`default_nettype none

module boot_ram (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  periph_pkg::mem_req_t  req_i,
    output periph_pkg::mem_rsp_t  rsp_o
);

    logic [periph_pkg::DATA_W-1:0] mem_q [periph_pkg::BOOT_WORDS];

    logic [periph_pkg::BOOT_IDX_W-1:0] idx;
    logic [periph_pkg::DATA_W-1:0]     rdata_q;
    logic                              valid_q;

    assign idx = req_i.addr[periph_pkg::BOOT_IDX_W+1:2]; // Word address

    // Byte-enabled write port
    always_ff @(posedge clk_i)
    begin
        if (req_i.valid && req_i.we)
        begin
            for (int b = 0; b < periph_pkg::BE_W; b++)
            begin
                if (req_i.be[b])
                begin
                    mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read data is registered and zero for writes
    always_ff @(posedge clk_i)
    begin
        if (req_i.valid)
        begin
            rdata_q <= req_i.we ? '0 : mem_q[idx];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= req_i.valid; // One cycle behind the request
        end
    end

    assign rsp_o.valid = valid_q;
    assign rsp_o.err   = 1'b0;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  periph_pkg::mem_req_t  req_i,
    output periph_pkg::mem_rsp_t  rsp_o,
    input  wire [7:0]             dip_i,
    output logic [7:0]            leds_o
);

    logic [2:0] ofs;
    logic [2:0] ofs_q;   // Offset seen in the response cycle
    logic       we_q;
    logic       valid_q;
    logic [7:0] leds_q;

    assign ofs = req_i.addr[5:3];

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            valid_q <= 1'b0;
            leds_q  <= '0;
        end
        else
        begin
            valid_q <= req_i.valid;
            // Other offsets take no writes
            if (req_i.valid && req_i.we && ofs == periph_pkg::GPIO_OFS_LEDS)
            begin
                leds_q <= req_i.wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        ofs_q <= ofs;
        we_q  <= req_i.we;
    end

    // ----------------------------------------
    // Readback decode
    // ----------------------------------------
    always_comb
    begin
        rsp_o.valid = valid_q;
        rsp_o.err   = 1'b0; // Unused offsets are not errors
        if (we_q)
        begin
            rsp_o.rdata = '0;
        end
        else if (ofs_q == periph_pkg::GPIO_OFS_LEDS)
        begin
            rsp_o.rdata = {24'd0, dip_i}; // Switches sampled live
        end
        else
        begin
            rsp_o.rdata = periph_pkg::FILLER_WORD;
        end
    end

    assign leds_o = leds_q;

endmodule

`default_nettype wire

// File: hw/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8; // One enable per byte

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam logic [ADDR_W-1:0] BOOT_BASE = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] BOOT_MASK = 32'h0000_FFFF; // Offset bits within region
    localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] GPIO_MASK = 32'h0000_0FFF;

    // Boot RAM geometry
    localparam int unsigned BOOT_WORDS = 256;
    localparam int unsigned BOOT_IDX_W = 8;   // Word index from addr[9:2]

    // GPIO register offsets come from addr[5:3]
    localparam logic [2:0] GPIO_OFS_LEDS = 3'd0; // LED write and DIP readback

    // Returned for unmapped regions and unused GPIO offsets
    localparam logic [DATA_W-1:0] FILLER_WORD = 32'hDEAD_BEEF;

    // ----------------------------------------
    // Request and response
    // ----------------------------------------

    // Single-cycle request strobe with its payload
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // Response arrives one cycle after the request
    typedef struct packed {
        logic              valid;
        logic              err;   // Address hit no region
        logic [DATA_W-1:0] rdata; // Zero for writes
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/periph_region_decode.sv
`timescale 1ns/10ps
`default_nettype none

module periph_region_decode (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  periph_pkg::mem_req_t  req_i,
    output periph_pkg::mem_req_t  boot_req_o,
    output periph_pkg::mem_req_t  gpio_req_o,
    input  periph_pkg::mem_rsp_t  boot_rsp_i,
    input  periph_pkg::mem_rsp_t  gpio_rsp_i,
    output periph_pkg::mem_rsp_t  rsp_o
);

    logic boot_hit;
    logic gpio_hit;
    logic miss;

    // Registered error path
    logic err_q;
    logic err_we_q;

    logic [periph_pkg::DATA_W-1:0] err_rdata;
    logic [periph_pkg::DATA_W-1:0] boot_rdata;
    logic [periph_pkg::DATA_W-1:0] gpio_rdata;

    // ----------------------------------------
    // Region match
    // ----------------------------------------

    // Drop the offset bits and compare what is left with the base
    assign boot_hit = (req_i.addr & ~periph_pkg::BOOT_MASK) == periph_pkg::BOOT_BASE;
    assign gpio_hit = (req_i.addr & ~periph_pkg::GPIO_MASK) == periph_pkg::GPIO_BASE;
    assign miss     = req_i.valid && !boot_hit && !gpio_hit;

    // ----------------------------------------
    // Strobe routing
    // ----------------------------------------
    always_comb
    begin
        boot_req_o       = req_i;
        boot_req_o.valid = req_i.valid && boot_hit; // Only the strobe is qualified
        gpio_req_o       = req_i;
        gpio_req_o.valid = req_i.valid && gpio_hit;
    end

    // ----------------------------------------
    // Error response
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            err_q <= 1'b0;
        end
        else
        begin
            err_q <= miss;
        end
    end

    // Write bit of the missed request
    always_ff @(posedge clk_i)
    begin
        err_we_q <= req_i.we;
    end

    // Reads of unmapped space see the filler word
    assign err_rdata = (err_q && !err_we_q) ? periph_pkg::FILLER_WORD : '0;

    // ----------------------------------------
    // Response merge
    // ----------------------------------------

    // Sources are mutually exclusive so an OR is enough
    assign boot_rdata = boot_rsp_i.valid ? boot_rsp_i.rdata : '0;
    assign gpio_rdata = gpio_rsp_i.valid ? gpio_rsp_i.rdata : '0;

    always_comb
    begin
        rsp_o.valid = boot_rsp_i.valid || gpio_rsp_i.valid || err_q;
        rsp_o.err   = err_q
                    || (boot_rsp_i.valid && boot_rsp_i.err)
                    || (gpio_rsp_i.valid && gpio_rsp_i.err);
        rsp_o.rdata = boot_rdata | gpio_rdata | err_rdata;
    end

endmodule

`default_nettype wire

// File: hw/periph_top.sv
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  periph_pkg::mem_req_t  req_i,
    output periph_pkg::mem_rsp_t  rsp_o,
    input  wire [7:0]             dip_i,
    output logic [7:0]            leds_o
);

    // Per-target request and response
    periph_pkg::mem_req_t boot_req;
    periph_pkg::mem_req_t gpio_req;
    periph_pkg::mem_rsp_t boot_rsp;
    periph_pkg::mem_rsp_t gpio_rsp;

    // ----------------------------------------
    // Region decoder
    // ----------------------------------------
    periph_region_decode i_decode (
        .clk_i      ( clk_i    ),
        .rst_n_i    ( rst_n_i  ),
        .req_i      ( req_i    ),
        .boot_req_o ( boot_req ),
        .gpio_req_o ( gpio_req ),
        .boot_rsp_i ( boot_rsp ),
        .gpio_rsp_i ( gpio_rsp ),
        .rsp_o      ( rsp_o    )
    );

    // ----------------------------------------
    // Targets
    // ----------------------------------------
    boot_ram i_boot_ram (
        .clk_i   ( clk_i    ),
        .rst_n_i ( rst_n_i  ),
        .req_i   ( boot_req ),
        .rsp_o   ( boot_rsp )
    );

    gpio_regs i_gpio_regs (
        .clk_i   ( clk_i    ),
        .rst_n_i ( rst_n_i  ),
        .req_i   ( gpio_req ),
        .rsp_o   ( gpio_rsp ),
        .dip_i   ( dip_i    ), // DIP switches in
        .leds_o  ( leds_o   )
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the periph_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module periph_tb -o Vperiph_tb \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vperiph_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"

// File: verif/periph_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module periph_assertions (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  periph_pkg::mem_req_t  req_i,
    input  periph_pkg::mem_rsp_t  rsp_i,
    input  wire [7:0]             leds_i
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    logic region_hit;

    assign region_hit = ((req_i.addr & ~periph_pkg::BOOT_MASK) == periph_pkg::BOOT_BASE)
                     || ((req_i.addr & ~periph_pkg::GPIO_MASK) == periph_pkg::GPIO_BASE);

    // ----------------------------------------
    // Response timing
    // ----------------------------------------
    rsp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.valid |=> rsp_i.valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("Request was not answered exactly one cycle later");
    end

    // No answer without a request one cycle earlier
    rsp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_i.valid |-> $past(req_i.valid))
    else
    begin
        fail_count = fail_count + 1;
        $error("Response appeared with no request in the previous cycle");
    end

    // ----------------------------------------
    // Error path and reset state
    // ----------------------------------------
    err_only_on_miss: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_i.err |-> $past(req_i.valid && !region_hit))
    else
    begin
        fail_count = fail_count + 1;
        $error("Error response for an address inside a region");
    end

    leds_clear_in_reset: assert property (@(posedge clk_i)
        (!rst_n_i && $past(!rst_n_i)) |-> (leds_i == 8'h00))
    else
    begin
        fail_count = fail_count + 1;
        $error("LEDs not cleared while reset is held");
    end

endmodule

bind periph_top periph_assertions i_checks (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( req_i   ),
    .rsp_i   ( rsp_o   ),
    .leds_i  ( leds_o  )
);

`default_nettype wire

// File: verif/periph_tb.sv
`timescale 1ns/10ps
`default_nettype none

module periph_tb;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_ROWS     = 22;
    localparam logic [31:0] SEED         = 32'haed2_0584;

    // One table row and what it should produce
    typedef struct packed {
        logic                          we;
        logic [periph_pkg::ADDR_W-1:0] addr;
        logic [periph_pkg::BE_W-1:0]   be;
        logic [periph_pkg::DATA_W-1:0] wdata;
        logic [7:0]                    dip;   // Switches held while the row runs
        logic [periph_pkg::DATA_W-1:0] exp_rdata;
        logic                          exp_err;
        logic [7:0]                    exp_leds;
    } row_t;

    logic                 clk_i;
    logic                 rst_n_i;
    periph_pkg::mem_req_t req_i;
    periph_pkg::mem_rsp_t rsp_o;
    logic [7:0]           dip_i;
    logic [7:0]           leds_o;

    row_t rows [NUM_ROWS];
    int   row_count = 0;

    periph_top periph_top_i (
        .clk_i   ( clk_i   ),
        .rst_n_i ( rst_n_i ),
        .req_i   ( req_i   ),
        .rsp_o   ( rsp_o   ),
        .dip_i   ( dip_i   ),
        .leds_o  ( leds_o  )
    );

    always
    begin
        #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Reporting and compares
    // ----------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_rsp(input periph_pkg::mem_rsp_t got, input periph_pkg::mem_rsp_t exp,
                             input int row);
        if (got.valid !== exp.valid)
        begin
            stop_on_error($sformatf("Mismatch rsp_o.valid (row %0d): got 0x%h, expected 0x%h",
                                    row, got.valid, exp.valid));
        end
        // Payload only matters in the response cycle
        if (exp.valid && got.err !== exp.err)
        begin
            stop_on_error($sformatf("Mismatch rsp_o.err (row %0d): got 0x%h, expected 0x%h",
                                    row, got.err, exp.err));
        end
        if (exp.valid && got.rdata !== exp.rdata)
        begin
            stop_on_error($sformatf("Mismatch rsp_o.rdata (row %0d): got 0x%h, expected 0x%h",
                                    row, got.rdata, exp.rdata));
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] exp, input int row);
        if (got !== exp)
        begin
            stop_on_error($sformatf("Mismatch leds_o (row %0d): got 0x%h, expected 0x%h",
                                    row, got, exp));
        end
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
            begin
                result[b*8 +: 8] = new_word[b*8 +: 8]; // Enabled lanes only
            end
        end
        return result;
    endfunction

    task automatic add_row(input row_t row);
        if (row_count >= NUM_ROWS)
        begin
            stop_on_error("Stimulus table has more rows than it was sized for");
        end
        rows[row_count] = row;
        row_count++;
    endtask

    task automatic add_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata, input logic exp_err,
                             input logic [7:0] exp_leds);
        row_t row;
        row.we        = 1'b1;
        row.addr      = addr;
        row.be        = be;
        row.wdata     = wdata;
        row.dip       = 8'($urandom);
        row.exp_rdata = 32'h0; // Writes answer with zero
        row.exp_err   = exp_err;
        row.exp_leds  = exp_leds;
        add_row(row);
    endtask

    task automatic add_read(input logic [31:0] addr, input logic [31:0] exp_rdata,
                            input logic exp_err, input logic [7:0] exp_leds,
                            input bit from_dip);
        row_t row;
        row.we        = 1'b0;
        row.addr      = addr;
        row.be        = 4'hF;
        row.wdata     = 32'h0;
        row.dip       = 8'($urandom);
        row.exp_rdata = from_dip ? {24'd0, row.dip} : exp_rdata;
        row.exp_err   = exp_err;
        row.exp_leds  = exp_leds;
        add_row(row);
    endtask

    task automatic build_table();
        logic [31:0] ram_w0;
        logic [31:0] ram_w1;
        logic [31:0] ram_mid;
        logic [31:0] ram_top;
        logic [31:0] gpio_led;
        logic [31:0] gpio_o2;
        logic [31:0] gpio_o5;
        logic [31:0] hole_a;
        logic [31:0] hole_b;
        logic [31:0] mid_merged;
        logic [31:0] w1_merged;

        ram_w0     = periph_pkg::BOOT_BASE;
        ram_w1     = periph_pkg::BOOT_BASE + 32'h004;
        ram_mid    = periph_pkg::BOOT_BASE + 32'h100; // Index 64
        ram_top    = periph_pkg::BOOT_BASE + 32'h3FC; // Last index
        gpio_led   = periph_pkg::GPIO_BASE;
        gpio_o2    = periph_pkg::GPIO_BASE + 32'h010;
        gpio_o5    = periph_pkg::GPIO_BASE + 32'h028;
        hole_a     = 32'h2000_0000;
        hole_b     = 32'h2001_0100; // Same low bits as ram_mid
        mid_merged = merge_bytes(32'hA5A5_5A5A, 32'h1122_3344, 4'b0101);
        w1_merged  = merge_bytes(32'hCAFE_F00D, 32'h7700_0000, 4'b1000);

        add_write(ram_w0, 4'hF, 32'h1234_5678, 1'b0, 8'h00);
        add_write(ram_w1, 4'hF, 32'hCAFE_F00D, 1'b0, 8'h00);
        add_write(ram_top, 4'hF, 32'h0BAD_C0DE, 1'b0, 8'h00);
        add_write(ram_mid, 4'hF, 32'hA5A5_5A5A, 1'b0, 8'h00);
        add_read(ram_w0, 32'h1234_5678, 1'b0, 8'h00, 1'b0);
        add_read(ram_w1, 32'hCAFE_F00D, 1'b0, 8'h00, 1'b0);
        add_read(ram_top, 32'h0BAD_C0DE, 1'b0, 8'h00, 1'b0);
        add_read(ram_mid, 32'hA5A5_5A5A, 1'b0, 8'h00, 1'b0);

        // Partial byte enables
        add_write(ram_mid, 4'b0101, 32'h1122_3344, 1'b0, 8'h00);
        add_read(ram_mid, mid_merged, 1'b0, 8'h00, 1'b0);
        add_write(ram_w1, 4'b1000, 32'h7700_0000, 1'b0, 8'h00);
        add_read(ram_w1, w1_merged, 1'b0, 8'h00, 1'b0);

        // GPIO block
        add_write(gpio_led, 4'hF, 32'h0000_00C3, 1'b0, 8'hC3);
        add_read(gpio_led, 32'h0, 1'b0, 8'hC3, 1'b1);
        add_read(gpio_o2, periph_pkg::FILLER_WORD, 1'b0, 8'hC3, 1'b0);
        add_write(gpio_o5, 4'hF, 32'h0000_00FF, 1'b0, 8'hC3);

        // Unmapped space must not touch RAM or LEDs
        add_read(hole_a, periph_pkg::FILLER_WORD, 1'b1, 8'hC3, 1'b0);
        add_write(hole_a, 4'hF, 32'hFFFF_FFFF, 1'b1, 8'hC3);
        add_write(hole_b, 4'hF, 32'h0000_0055, 1'b1, 8'hC3);
        add_read(ram_mid, mid_merged, 1'b0, 8'hC3, 1'b0);
        add_read(gpio_led, 32'h0, 1'b0, 8'hC3, 1'b1);
        add_write(gpio_led, 4'hF, 32'h0000_1A3C, 1'b0, 8'h3C);

        if (row_count != NUM_ROWS)
        begin
            stop_on_error("Stimulus table row count does not match its size");
        end
    endtask

    // One request, one idle cycle, then the response check
    task automatic apply_row(input int idx);
        row_t                 row;
        periph_pkg::mem_req_t drv;
        periph_pkg::mem_rsp_t exp;
        row       = rows[idx];
        drv.valid = 1'b1;
        drv.we    = row.we;
        drv.addr  = row.addr;
        drv.be    = row.be;
        drv.wdata = row.wdata;
        @(posedge clk_i);
        req_i <= drv;
        dip_i <= row.dip;
        @(negedge clk_i);
        exp = '0;
        check_rsp(rsp_o, exp, idx); // Nothing answers yet
        @(posedge clk_i);
        drv.valid = 1'b0;
        req_i <= drv;
        @(negedge clk_i);
        exp.valid = 1'b1;
        exp.err   = row.exp_err;
        exp.rdata = row.exp_rdata;
        check_rsp(rsp_o, exp, idx);
        check_leds(leds_o, row.exp_leds, idx);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        periph_pkg::mem_rsp_t idle_rsp;
        void'($urandom(SEED));
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        req_i   = '0;
        dip_i   = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        idle_rsp = '0;
        check_rsp(rsp_o, idle_rsp, -1);
        check_leds(leds_o, 8'h00, -1);
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            apply_row(i);
        end
        if (periph_top_i.i_checks.fail_count != 0)
        begin
            stop_on_error("A bound assertion failed during the run");
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

    // Watchdog sized from the table length
    initial
    begin
        #((NUM_ROWS * 4 + 20) * CLK_PERIOD);
        stop_on_error("Timeout: the run did not finish in the expected time");
    end

endmodule

`default_nettype wire
